// ==== logic/cache_block_pkg.sv ====
`default_nettype none

package cache_block_pkg;

    // lane and bank geometry
    localparam int NUM_LANES  = 4;
    localparam int NUM_PAIRS  = 2;
    localparam int BANK_DEPTH = 16;

    // field widths
    localparam int DATA_W  = 32;
    localparam int BLOCK_W = 3;
    localparam int ROW_W   = 4;
    localparam int TAG_W   = 6;

    typedef enum logic [1:0] {
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } opcode_e;

    // command as it travels on the read and write command chains
    typedef struct packed {
        logic [BLOCK_W-1:0] block_id;
        logic               bank_id;
        logic [ROW_W-1:0]   row;
        logic [TAG_W-1:0]   tag;
        opcode_e            opcode;
    } cache_cmd_t;

    // one word on the east or west data chain
    typedef struct packed {
        cache_cmd_t         cmd;
        logic [DATA_W-1:0]  data;
    } chain_word_t;

endpackage

`default_nettype wire

// ==== logic/bank_req_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface bank_req_if
    import cache_block_pkg::*;
();

    // one entry per lane of the pair, even lane first
    logic [1:0]       rd_vld;
    cache_cmd_t [1:0] rd_cmd;
    logic [1:0]       wr_vld;
    cache_cmd_t [1:0] wr_cmd;

    modport decoder (output rd_vld, output rd_cmd, output wr_vld, output wr_cmd);

    modport bank (input rd_vld, input rd_cmd, input wr_vld, input wr_cmd);

endinterface

`default_nettype wire

// ==== logic/lane_cmd_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_cmd_decode
    import cache_block_pkg::*;
#(
    parameter logic [BLOCK_W-1:0] BLOCK_ID = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [1:0]       rd_vld,
    input  cache_cmd_t [1:0] rd_cmd,
    input  logic [1:0]       wr_vld,
    input  cache_cmd_t [1:0] wr_cmd,
    bank_req_if.decoder      req,
    output logic [1:0]       ret_vld,
    output cache_cmd_t [1:0] ret_cmd
);

    logic [1:0]       rd_match;
    logic [1:0]       rd_acc;
    logic [1:0]       wr_match;
    logic [1:0]       wr_vld_q;
    cache_cmd_t [1:0] wr_cmd_q;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            rd_match[l] = rd_vld[l] && (rd_cmd[l].block_id == BLOCK_ID);
            wr_match[l] = wr_vld[l] && (wr_cmd[l].block_id == BLOCK_ID);
        end
    end

    // odd lane loses its read when the even lane takes the same bank
    assign rd_acc[0] = rd_match[0];
    assign rd_acc[1] = rd_match[1]
                    && !(rd_match[0] && (rd_cmd[0].bank_id == rd_cmd[1].bank_id));

    // reads hit the banks in the same cycle
    assign req.rd_vld = rd_match;
    assign req.rd_cmd = rd_cmd;

    // writes wait one cycle so they meet their data word
    assign req.wr_vld = wr_vld_q;
    assign req.wr_cmd = wr_cmd_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_vld_q <= '0;
            ret_vld  <= '0;
        end else begin
            wr_vld_q <= wr_match;
            ret_vld  <= rd_acc;
        end
    end

    always_ff @(posedge clk) begin
        wr_cmd_q <= wr_cmd;
        ret_cmd  <= rd_cmd;
    end

endmodule

`default_nettype wire

// ==== logic/bank_pair.sv ====
`timescale 1ns/1ns
`default_nettype none

module bank_pair
    import cache_block_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    bank_req_if.bank               req,
    input  logic [1:0][DATA_W-1:0] wr_data,
    output logic [1:0][DATA_W-1:0] rd_data
);

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [DATA_W-1:0] mem [BANK_DEPTH];
        logic [1:0]        rd_hit;
        logic [1:0]        wr_hit;
        logic              rd_en;
        logic              wr_en;
        logic [ROW_W-1:0]  rd_row;
        logic [ROW_W-1:0]  wr_row;
        logic [DATA_W-1:0] rd_q;

        // lanes that target this bank
        assign rd_hit[0] = req.rd_vld[0] && (req.rd_cmd[0].bank_id == 1'(b));
        assign rd_hit[1] = req.rd_vld[1] && (req.rd_cmd[1].bank_id == 1'(b));
        assign wr_hit[0] = req.wr_vld[0] && (req.wr_cmd[0].bank_id == 1'(b));
        assign wr_hit[1] = req.wr_vld[1] && (req.wr_cmd[1].bank_id == 1'(b));

        // even lane has priority
        assign rd_en  = |rd_hit;
        assign wr_en  = |wr_hit;
        assign rd_row = rd_hit[0] ? req.rd_cmd[0].row : req.rd_cmd[1].row;
        assign wr_row = wr_hit[0] ? req.wr_cmd[0].row : req.wr_cmd[1].row;

        // read before write on the same row returns the old word
        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_row] <= wr_data[b];
            end
            if (rd_en) begin
                rd_q <= mem[rd_row];
            end
        end

        assign rd_data[b] = rd_q;
    end

    // both lanes of a pair must not share a bank port in one cycle
    a_rd_bank_conflict: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req.rd_vld[0] && req.rd_vld[1]
          && (req.rd_cmd[0].bank_id == req.rd_cmd[1].bank_id))
    ) else $error("read conflict on one bank, odd lane dropped");

    a_wr_bank_conflict: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(req.wr_vld[0] && req.wr_vld[1]
          && (req.wr_cmd[0].bank_id == req.wr_cmd[1].bank_id))
    ) else $error("write conflict on one bank, odd lane dropped");

endmodule

`default_nettype wire

// ==== logic/read_return_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module read_return_merge
    import cache_block_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [NUM_LANES-1:0]                  ret_vld,
    input  cache_cmd_t [NUM_LANES-1:0]            ret_cmd,
    input  logic [NUM_LANES-1:0][1:0][DATA_W-1:0] rd_data,
    input  logic [NUM_LANES-1:0]                  west_data_vld_in,
    input  chain_word_t [NUM_LANES-1:0]           west_data_in,
    output logic [NUM_LANES-1:0]                  east_data_vld_out,
    output chain_word_t [NUM_LANES-1:0]           east_data_out
);

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (ret_vld[l]) begin
                // local result takes the slot
                east_data_vld_out[l]  = 1'b1;
                east_data_out[l].cmd  = ret_cmd[l];
                east_data_out[l].data = rd_data[l][ret_cmd[l].bank_id];
            end else begin
                east_data_vld_out[l] = west_data_vld_in[l];
                east_data_out[l]     = west_data_in[l];
            end
        end
    end

    // a passing word in the same slot as a read result would vanish
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
        a_slot_collision: assert property (
            @(posedge clk) disable iff (!rst_n)
            !(ret_vld[l] && west_data_vld_in[l])
        ) else $error("read return overwrote a valid west data word on lane %0d", l);
    end

endmodule

`default_nettype wire

// ==== logic/write_data_steer.sv ====
`timescale 1ns/1ns
`default_nettype none

module write_data_steer
    import cache_block_pkg::*;
#(
    parameter logic [BLOCK_W-1:0] BLOCK_ID = '0
) (
    input  logic [NUM_LANES-1:0]                  east_data_vld_in,
    input  chain_word_t [NUM_LANES-1:0]           east_data_in,
    output logic [NUM_PAIRS-1:0][1:0][DATA_W-1:0] wr_data,
    output logic [NUM_LANES-1:0]                  west_data_vld_out,
    output chain_word_t [NUM_LANES-1:0]           west_data_out
);

    logic [NUM_LANES-1:0] consume;

    // write words addressed to this block stop here
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            consume[l] = east_data_vld_in[l]
                      && (east_data_in[l].cmd.opcode == OP_WRITE)
                      && (east_data_in[l].cmd.block_id == BLOCK_ID);
        end
    end

    assign west_data_out     = east_data_in;
    assign west_data_vld_out = east_data_vld_in & ~consume;

    // per bank, even lane first, odd lane otherwise
    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int b = 0; b < 2; b++) begin
                if (consume[2*p] && (east_data_in[2*p].cmd.bank_id == 1'(b))) begin
                    wr_data[p][b] = east_data_in[2*p].data;
                end else begin
                    wr_data[p][b] = east_data_in[2*p+1].data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cache_block_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cache_block_top
    import cache_block_pkg::*;
#(
    parameter logic [BLOCK_W-1:0] BLOCK_ID = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic [NUM_LANES-1:0]        west_rd_vld_in,
    input  cache_cmd_t [NUM_LANES-1:0]  west_rd_cmd_in,
    output logic [NUM_LANES-1:0]        west_rd_vld_out,
    output cache_cmd_t [NUM_LANES-1:0]  west_rd_cmd_out,
    input  logic [NUM_LANES-1:0]        east_rd_vld_in,
    input  cache_cmd_t [NUM_LANES-1:0]  east_rd_cmd_in,
    output logic [NUM_LANES-1:0]        east_rd_vld_out,
    output cache_cmd_t [NUM_LANES-1:0]  east_rd_cmd_out,

    input  logic [NUM_LANES-1:0]        west_wr_vld_in,
    input  cache_cmd_t [NUM_LANES-1:0]  west_wr_cmd_in,
    output logic [NUM_LANES-1:0]        west_wr_vld_out,
    output cache_cmd_t [NUM_LANES-1:0]  west_wr_cmd_out,
    input  logic [NUM_LANES-1:0]        east_wr_vld_in,
    input  cache_cmd_t [NUM_LANES-1:0]  east_wr_cmd_in,
    output logic [NUM_LANES-1:0]        east_wr_vld_out,
    output cache_cmd_t [NUM_LANES-1:0]  east_wr_cmd_out,

    input  logic [NUM_LANES-1:0]        west_data_vld_in,
    input  chain_word_t [NUM_LANES-1:0] west_data_in,
    output logic [NUM_LANES-1:0]        east_data_vld_out,
    output chain_word_t [NUM_LANES-1:0] east_data_out,
    input  logic [NUM_LANES-1:0]        east_data_vld_in,
    input  chain_word_t [NUM_LANES-1:0] east_data_in,
    output logic [NUM_LANES-1:0]        west_data_vld_out,
    output chain_word_t [NUM_LANES-1:0] west_data_out
);

    logic [NUM_LANES-1:0]                  ret_vld;
    cache_cmd_t [NUM_LANES-1:0]            ret_cmd;
    logic [NUM_PAIRS-1:0][1:0][DATA_W-1:0] pair_rd_data;
    logic [NUM_PAIRS-1:0][1:0][DATA_W-1:0] pair_wr_data;
    logic [NUM_LANES-1:0][1:0][DATA_W-1:0] lane_rd_data;

    // commands pass straight through in both directions
    assign east_rd_vld_out = west_rd_vld_in;
    assign east_rd_cmd_out = west_rd_cmd_in;
    assign west_rd_vld_out = east_rd_vld_in;
    assign west_rd_cmd_out = east_rd_cmd_in;
    assign east_wr_vld_out = west_wr_vld_in;
    assign east_wr_cmd_out = west_wr_cmd_in;
    assign west_wr_vld_out = east_wr_vld_in;
    assign west_wr_cmd_out = east_wr_cmd_in;

    for (genvar p = 0; p < NUM_PAIRS; p++) begin : g_pair
        bank_req_if i_req ();

        // reads come from the west side, writes from the east side
        lane_cmd_decode #(
            .BLOCK_ID (BLOCK_ID)
        ) i_lane_cmd_decode (
            .clk     (clk),
            .rst_n   (rst_n),
            .rd_vld  (west_rd_vld_in[2*p +: 2]),
            .rd_cmd  (west_rd_cmd_in[2*p +: 2]),
            .wr_vld  (east_wr_vld_in[2*p +: 2]),
            .wr_cmd  (east_wr_cmd_in[2*p +: 2]),
            .req     (i_req.decoder),
            .ret_vld (ret_vld[2*p +: 2]),
            .ret_cmd (ret_cmd[2*p +: 2])
        );

        bank_pair i_bank_pair (
            .clk     (clk),
            .rst_n   (rst_n),
            .req     (i_req.bank),
            .wr_data (pair_wr_data[p]),
            .rd_data (pair_rd_data[p])
        );

        // both lanes of a pair see the same two banks
        assign lane_rd_data[2*p]   = pair_rd_data[p];
        assign lane_rd_data[2*p+1] = pair_rd_data[p];
    end

    read_return_merge i_read_return_merge (
        .clk               (clk),
        .rst_n             (rst_n),
        .ret_vld           (ret_vld),
        .ret_cmd           (ret_cmd),
        .rd_data           (lane_rd_data),
        .west_data_vld_in  (west_data_vld_in),
        .west_data_in      (west_data_in),
        .east_data_vld_out (east_data_vld_out),
        .east_data_out     (east_data_out)
    );

    write_data_steer #(
        .BLOCK_ID (BLOCK_ID)
    ) i_write_data_steer (
        .east_data_vld_in  (east_data_vld_in),
        .east_data_in      (east_data_in),
        .wr_data           (pair_wr_data),
        .west_data_vld_out (west_data_vld_out),
        .west_data_out     (west_data_out)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release a little after the edge so it never races the flops
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cache_block.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cache_block
    import cache_block_pkg::*;
();

    localparam logic [BLOCK_W-1:0] TB_BLOCK = 3'd2;
    localparam int NUM_CYCLES = 1500;
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic rst_n;
    logic [NUM_LANES-1:0]        west_rd_vld_in, west_rd_vld_out, east_rd_vld_in, east_rd_vld_out;
    cache_cmd_t [NUM_LANES-1:0]  west_rd_cmd_in, west_rd_cmd_out, east_rd_cmd_in, east_rd_cmd_out;
    logic [NUM_LANES-1:0]        west_wr_vld_in, west_wr_vld_out, east_wr_vld_in, east_wr_vld_out;
    cache_cmd_t [NUM_LANES-1:0]  west_wr_cmd_in, west_wr_cmd_out, east_wr_cmd_in, east_wr_cmd_out;
    logic [NUM_LANES-1:0]        west_data_vld_in, east_data_vld_out;
    logic [NUM_LANES-1:0]        east_data_vld_in, west_data_vld_out;
    chain_word_t [NUM_LANES-1:0] west_data_in, east_data_out, east_data_in, west_data_out;

    // reference memory indexed by pair, bank and row
    logic [DATA_W-1:0] model [NUM_PAIRS][2][BANK_DEPTH];
    logic              known [NUM_PAIRS][2][BANK_DEPTH];
    logic [NUM_LANES-1:0] wr_pend;
    cache_cmd_t           wr_pend_cmd [NUM_LANES];
    logic [NUM_LANES-1:0] exp_ret;
    logic [NUM_LANES-1:0] exp_chk;
    logic [NUM_LANES-1:0] exp_par;
    logic [DATA_W-1:0]    exp_data [NUM_LANES];
    logic [TAG_W-1:0]     exp_tag [NUM_LANES];
    logic                 rst_seen;
    int                   cycle_cnt;

    tb_clock_gen #(.PERIOD(20), .RST_CYCLES(5)) i_tb_clock_gen (.clk(clk), .rst_n(rst_n));

    cache_block_top #(.BLOCK_ID(TB_BLOCK)) i_cache_block_top (.*);

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("FAILED %s expected %h actual %h", name, exp_val, act_val);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic cache_cmd_t make_cmd(input logic [BLOCK_W-1:0] blk, input logic bank,
                                            input opcode_e op);
        cache_cmd_t c;
        c.block_id = blk;
        c.bank_id  = bank;
        c.row      = ROW_W'($urandom_range(0, BANK_DEPTH - 1));
        c.tag      = TAG_W'($urandom_range(0, 63));
        c.opcode   = op;
        return c;
    endfunction

    // mostly this block, sometimes a foreign one
    function automatic logic [BLOCK_W-1:0] pick_block();
        return ($urandom_range(0, 3) == 0) ? 3'd5 : TB_BLOCK;
    endfunction

    initial begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            for (int b = 0; b < 2; b++) begin
                for (int r = 0; r < BANK_DEPTH; r++) begin
                    known[p][b][r] = 1'b0;
                end
            end
        end
    end

    // model update and expected read returns
    always @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (rst_n && wr_pend[l] && east_data_vld_in[l]) begin
                model[l/2][wr_pend_cmd[l].bank_id][wr_pend_cmd[l].row] <= east_data_in[l].data;
                known[l/2][wr_pend_cmd[l].bank_id][wr_pend_cmd[l].row] <= 1'b1;
            end
            wr_pend[l]     <= rst_n && east_wr_vld_in[l] && east_wr_cmd_in[l].block_id == TB_BLOCK;
            wr_pend_cmd[l] <= east_wr_cmd_in[l];
            exp_ret[l]  <= rst_n && west_rd_vld_in[l] && west_rd_cmd_in[l].block_id == TB_BLOCK;
            exp_chk[l]  <= rst_n && west_rd_vld_in[l] && west_rd_cmd_in[l].block_id == TB_BLOCK
                           && known[l/2][west_rd_cmd_in[l].bank_id][west_rd_cmd_in[l].row];
            exp_data[l] <= model[l/2][west_rd_cmd_in[l].bank_id][west_rd_cmd_in[l].row];
            exp_tag[l]  <= west_rd_cmd_in[l].tag;
            exp_par[l]  <= west_rd_vld_in[l & ~1] && west_rd_vld_in[l | 1]
                           && west_rd_cmd_in[l & ~1].block_id == TB_BLOCK
                           && west_rd_cmd_in[l | 1].block_id == TB_BLOCK;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_seen <= 1'b0;
        end else begin
            rst_seen <= 1'b1;
        end
    end

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
        a_pass_rd: assert property (@(posedge clk)
            {east_rd_vld_out[l], east_rd_cmd_out[l], west_rd_vld_out[l], west_rd_cmd_out[l]}
            == {west_rd_vld_in[l], west_rd_cmd_in[l], east_rd_vld_in[l], east_rd_cmd_in[l]})
            else report_mismatch("pass_through",
                64'($sampled({west_rd_vld_in[l], west_rd_cmd_in[l], east_rd_vld_in[l],
                              east_rd_cmd_in[l]})),
                64'($sampled({east_rd_vld_out[l], east_rd_cmd_out[l], west_rd_vld_out[l],
                              west_rd_cmd_out[l]})));

        a_pass_wr: assert property (@(posedge clk)
            {east_wr_vld_out[l], east_wr_cmd_out[l], west_wr_vld_out[l], west_wr_cmd_out[l]}
            == {west_wr_vld_in[l], west_wr_cmd_in[l], east_wr_vld_in[l], east_wr_cmd_in[l]})
            else report_mismatch("pass_through",
                64'($sampled({west_wr_vld_in[l], west_wr_cmd_in[l], east_wr_vld_in[l],
                              east_wr_cmd_in[l]})),
                64'($sampled({east_wr_vld_out[l], east_wr_cmd_out[l], west_wr_vld_out[l],
                              west_wr_cmd_out[l]})));

        a_read: assert property (@(posedge clk) disable iff (!rst_n)
            exp_chk[l] |-> {east_data_vld_out[l], east_data_out[l].cmd.tag,
                            east_data_out[l].data} == {1'b1, exp_tag[l], exp_data[l]})
            else report_mismatch($sampled(exp_par[l]) ? "parallel_banks" : "write_read",
                64'($sampled({1'b1, exp_tag[l], exp_data[l]})),
                64'($sampled({east_data_vld_out[l], east_data_out[l].cmd.tag,
                              east_data_out[l].data})));

        a_foreign: assert property (@(posedge clk) disable iff (!rst_n)
            (west_rd_vld_in[l] && west_rd_cmd_in[l].block_id != TB_BLOCK && !exp_ret[l])
            |-> {east_data_vld_out[l], east_data_out[l]} == {west_data_vld_in[l], west_data_in[l]})
            else report_mismatch("foreign_read",
                64'($sampled({west_data_vld_in[l], west_data_in[l]})),
                64'($sampled({east_data_vld_out[l], east_data_out[l]})));

        // only the data word of a pending write for this block is taken off the chain
        a_consume: assert property (@(posedge clk) disable iff (!rst_n)
            east_data_vld_in[l] |-> {west_data_vld_out[l], west_data_out[l]}
            == {!wr_pend[l], east_data_in[l]})
            else report_mismatch("write_consume",
                64'($sampled({!wr_pend[l], east_data_in[l]})),
                64'($sampled({west_data_vld_out[l], west_data_out[l]})));
    end

    a_reset: assert property (@(posedge clk) !rst_seen |-> east_data_vld_out == '0)
        else report_mismatch("reset_state", 64'd0, 64'($sampled(east_data_vld_out)));

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    initial begin
        logic                 b;
        logic [NUM_LANES-1:0] pend;
        cache_cmd_t           pend_cmd [NUM_LANES];
        cycle_cnt = 0;
        pend = '0;
        void'($urandom(48));
        {west_rd_vld_in, west_rd_cmd_in, east_rd_vld_in, east_rd_cmd_in} = '0;
        {west_wr_vld_in, west_wr_cmd_in, east_wr_vld_in, east_wr_cmd_in} = '0;
        {west_data_vld_in, west_data_in, east_data_vld_in, east_data_in} = '0;
        @(posedge rst_n);
        repeat (2) @(posedge clk);
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            #1;
            // write data follows its command by one cycle
            // strays never target this block
            for (int l = 0; l < NUM_LANES; l++) begin
                if (pend[l]) begin
                    east_data_vld_in[l] = 1'b1;
                    east_data_in[l] = {pend_cmd[l], DATA_W'($urandom)};
                end else begin
                    east_data_vld_in[l] = 1'($urandom_range(0, 1));
                    east_data_in[l].cmd = $urandom_range(0, 1)
                        ? make_cmd(TB_BLOCK, 1'($urandom_range(0, 1)), OP_READ)
                        : make_cmd(3'd6, 1'($urandom_range(0, 1)), OP_WRITE);
                    east_data_in[l].data = DATA_W'($urandom);
                end
                // keep the slot free where a read result comes back
                west_data_vld_in[l] = exp_ret[l] ? 1'b0 : 1'($urandom_range(0, 1));
                west_data_in[l] = {make_cmd(3'($urandom), 1'($urandom_range(0, 1)), OP_READ),
                                   DATA_W'($urandom)};
                east_rd_vld_in[l] = 1'($urandom_range(0, 1));
                east_rd_cmd_in[l] = make_cmd(3'($urandom), 1'($urandom_range(0, 1)), OP_READ);
                west_wr_vld_in[l] = 1'($urandom_range(0, 1));
                west_wr_cmd_in[l] = make_cmd(3'($urandom), 1'($urandom_range(0, 1)), OP_WRITE);
            end
            // lanes of a pair always use different banks
            for (int p = 0; p < NUM_PAIRS; p++) begin
                b = 1'($urandom_range(0, 1));
                west_rd_vld_in[2*p]   = 1'($urandom_range(0, 1));
                west_rd_cmd_in[2*p]   = make_cmd(pick_block(), b, OP_READ);
                west_rd_vld_in[2*p+1] = 1'($urandom_range(0, 1));
                west_rd_cmd_in[2*p+1] = make_cmd(pick_block(), ~b, OP_READ);
                b = 1'($urandom_range(0, 1));
                east_wr_vld_in[2*p]   = 1'($urandom_range(0, 1));
                east_wr_cmd_in[2*p]   = make_cmd(pick_block(), b, OP_WRITE);
                east_wr_vld_in[2*p+1] = 1'($urandom_range(0, 1));
                east_wr_cmd_in[2*p+1] = make_cmd(pick_block(), ~b, OP_WRITE);
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                pend[l]     = east_wr_vld_in[l];
                pend_cmd[l] = east_wr_cmd_in[l];
            end
        end
        @(posedge clk);
        #1;
        {west_rd_vld_in, east_rd_vld_in, west_wr_vld_in, east_wr_vld_in} = '0;
        {west_data_vld_in, east_data_vld_in} = '0;
        repeat (3) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/cache_block_pkg.sv
logic/bank_req_if.sv
logic/lane_cmd_decode.sv
logic/bank_pair.sv
logic/read_return_merge.sv
logic/write_data_steer.sv
logic/cache_block_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cache_block.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cache_block -f vlog.f \
    -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without passing, see sim.log"; exit 1; }
echo "simulation passed"
